// File: design/inp_map_pkg.sv
package inp_map_pkg;

    localparam int joy_w      = 16; // raw board joystick word
    localparam int game_joy_w = 10; // joystick word seen by the game
    localparam int buttons    = 2;
    localparam int n_players  = 4;

    // direction nibble, low bits of every joystick word
    localparam int dir_right = 0;
    localparam int dir_left  = 1;
    localparam int dir_down  = 2;
    localparam int dir_up    = 3;

    // control bits sit just above the action buttons
    localparam int start_bit = 6 + (buttons - 2);
    localparam int coin_bit  = 7 + (buttons - 2);
    localparam int pause_bit = 8 + (buttons - 2);

    localparam logic active_low = 1'b1; // game side expects low-true inputs

endpackage

// File: design/inp_cfg_pkg.sv
package inp_cfg_pkg;

    // register map, byte addresses
    localparam logic [3:0] addr_ctrl   = 4'h0;
    localparam logic [3:0] addr_status = 4'h4;

    // control register fields
    localparam int ctrl_rot  = 0; // cabinet turned on its side
    localparam int ctrl_flip = 1; // rotation direction
    localparam int ctrl_4way = 2; // 4-way joystick filter
    localparam int ctrl_lock = 3; // block all player inputs

    // status word
    localparam int stat_pause = 0;

endpackage

// File: design/inp_cfg_apb.sv
`timescale 1ns/1ps

module inp_cfg_apb (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    input  logic        game_pause,
    output logic        rot,
    output logic        flip,
    output logic        en4way,
    output logic        lock
);

    logic [3:0]  ctrl_q;
    logic        access;
    logic        hit_ctrl;
    logic        hit_status;
    logic [31:0] status_word;

    assign access     = psel & penable;
    assign hit_ctrl   = paddr == inp_cfg_pkg::addr_ctrl;
    assign hit_status = paddr == inp_cfg_pkg::addr_status;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q <= '0;
        end else if (access && pwrite && hit_ctrl) begin
            ctrl_q <= pwdata[3:0];
        end
    end

    // live pause state, rest of the word reads as zero
    always_comb begin
        status_word = '0;
        status_word[inp_cfg_pkg::stat_pause] = game_pause;
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            if (hit_ctrl)
                prdata = {28'd0, ctrl_q};
            else if (hit_status)
                prdata = status_word;
        end
    end

    assign pslverr = access & ~(hit_ctrl | hit_status); // unmapped address

    assign rot    = ctrl_q[inp_cfg_pkg::ctrl_rot];
    assign flip   = ctrl_q[inp_cfg_pkg::ctrl_flip];
    assign en4way = ctrl_q[inp_cfg_pkg::ctrl_4way];
    assign lock   = ctrl_q[inp_cfg_pkg::ctrl_lock];

endmodule

// File: design/joy_4way_filter.sv
`timescale 1ns/1ps

module joy_4way_filter (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic [3:0] dir_in,
    output logic [3:0] dir_out
);

    logic [3:0] last_dir; // last single direction given out
    logic       single;

    assign single = (dir_in != 4'd0) && ((dir_in & (dir_in - 4'd1)) == 4'd0);

    always_comb begin
        dir_out = 4'd0;
        if (!enable || single) begin
            dir_out = dir_in;
        end else if ((dir_in & last_dir) != 4'd0) begin
            dir_out = last_dir; // diagonal keeps the held direction
        end else if (dir_in[inp_map_pkg::dir_up]) begin
            dir_out[inp_map_pkg::dir_up] = 1'b1;
        end else if (dir_in[inp_map_pkg::dir_down]) begin
            dir_out[inp_map_pkg::dir_down] = 1'b1;
        end else if (dir_in[inp_map_pkg::dir_left]) begin
            dir_out[inp_map_pkg::dir_left] = 1'b1;
        end else if (dir_in[inp_map_pkg::dir_right]) begin
            dir_out[inp_map_pkg::dir_right] = 1'b1;
        end
    end

    // no press leaves the memory alone
    always_ff @(posedge clk) begin
        if (rst) begin
            last_dir <= 4'd0;
        end else if (enable && dir_out != 4'd0) begin
            last_dir <= dir_out;
        end else if (single) begin
            last_dir <= dir_in;
        end
    end

endmodule

// File: design/inp_sync_stage.sv
`timescale 1ns/1ps

module inp_sync_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [inp_map_pkg::joy_w-1:0] board_joy1,
    input  logic [inp_map_pkg::joy_w-1:0] board_joy2,
    input  logic [inp_map_pkg::joy_w-1:0] board_joy3,
    input  logic [inp_map_pkg::joy_w-1:0] board_joy4,
    input  logic                        board_coin,
    input  logic                        board_start,
    input  logic                        en4way,
    output logic [inp_map_pkg::joy_w-1:0] board_sync1,
    output logic [inp_map_pkg::joy_w-1:0] board_sync2,
    output logic [inp_map_pkg::joy_w-1:0] board_sync3,
    output logic [inp_map_pkg::joy_w-1:0] board_sync4,
    output logic                        coin_sync,
    output logic                        start_sync
);

    localparam int w = inp_map_pkg::joy_w;

    logic [w-1:0] joy_in [4];
    logic [w-1:0] sync1  [4]; // first flop, may be metastable
    logic [w-1:0] sync2  [4];
    logic [w-1:0] joy_out[4];
    logic [1:0]   scalar1, scalar2;

    assign joy_in = '{board_joy1, board_joy2, board_joy3, board_joy4};

    for (genvar p = 0; p < 4; p++) begin : g_player
        always_ff @(posedge clk) begin
            sync1[p] <= joy_in[p];
            sync2[p] <= sync1[p];
        end

        joy_4way_filter u_filter (
            .clk     (clk),
            .rst     (rst),
            .enable  (en4way),
            .dir_in  (sync2[p][3:0]),
            .dir_out (joy_out[p][3:0])
        );

        assign joy_out[p][w-1:4] = sync2[p][w-1:4];
    end

    always_ff @(posedge clk) begin
        scalar1 <= {board_start, board_coin};
        scalar2 <= scalar1;
    end

    assign board_sync1 = joy_out[0];
    assign board_sync2 = joy_out[1];
    assign board_sync3 = joy_out[2];
    assign board_sync4 = joy_out[3];
    assign coin_sync   = scalar2[0];
    assign start_sync  = scalar2[1];

endmodule

// File: design/inp_merge_stage.sv
`timescale 1ns/1ps

module inp_merge_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [inp_map_pkg::joy_w-1:0]   board_sync1,
    input  logic [inp_map_pkg::joy_w-1:0]   board_sync2,
    input  logic [inp_map_pkg::joy_w-1:0]   board_sync3,
    input  logic [inp_map_pkg::joy_w-1:0]   board_sync4,
    input  logic                          coin_sync,
    input  logic                          start_sync,
    input  logic [inp_map_pkg::game_joy_w-1:0] key_joy1,
    input  logic [inp_map_pkg::game_joy_w-1:0] key_joy2,
    input  logic [inp_map_pkg::game_joy_w-1:0] key_joy3,
    input  logic [3:0]                    key_coin,
    input  logic [3:0]                    key_start,
    input  logic                          rot,
    input  logic                          flip,
    output logic [inp_map_pkg::game_joy_w-1:0] m_joy1,
    output logic [inp_map_pkg::game_joy_w-1:0] m_joy2,
    output logic [inp_map_pkg::game_joy_w-1:0] m_joy3,
    output logic [inp_map_pkg::game_joy_w-1:0] m_joy4,
    output logic [3:0]                    m_coin,
    output logic [3:0]                    m_start,
    output logic                          m_joy_pause
);

    localparam int gw = inp_map_pkg::game_joy_w;

    function automatic logic [gw-1:0] rotate(input logic [gw-1:0] j, input logic r,
                                             input logic f);
        logic [gw-1:0] res;
        res = j;
        if (r && !f) begin
            res[inp_map_pkg::dir_up]    = j[inp_map_pkg::dir_left];
            res[inp_map_pkg::dir_down]  = j[inp_map_pkg::dir_right];
            res[inp_map_pkg::dir_left]  = j[inp_map_pkg::dir_down];
            res[inp_map_pkg::dir_right] = j[inp_map_pkg::dir_up];
        end else if (r) begin // other way round
            res[inp_map_pkg::dir_up]    = j[inp_map_pkg::dir_right];
            res[inp_map_pkg::dir_down]  = j[inp_map_pkg::dir_left];
            res[inp_map_pkg::dir_left]  = j[inp_map_pkg::dir_up];
            res[inp_map_pkg::dir_right] = j[inp_map_pkg::dir_down];
        end
        return res;
    endfunction

    logic [3:0] coin_all, start_all;

    assign coin_all = {board_sync4[inp_map_pkg::coin_bit], board_sync3[inp_map_pkg::coin_bit],
                       board_sync2[inp_map_pkg::coin_bit], board_sync1[inp_map_pkg::coin_bit]}
                      | key_coin | {3'd0, coin_sync}; // board scalar is player 1 only
    assign start_all = {board_sync4[inp_map_pkg::start_bit], board_sync3[inp_map_pkg::start_bit],
                        board_sync2[inp_map_pkg::start_bit], board_sync1[inp_map_pkg::start_bit]}
                       | key_start | {3'd0, start_sync};

    always_ff @(posedge clk) begin
        if (rst) begin
            m_joy1      <= '0;
            m_joy2      <= '0;
            m_joy3      <= '0;
            m_joy4      <= '0;
            m_coin      <= '0;
            m_start     <= '0;
            m_joy_pause <= 1'b0;
        end else begin
            m_joy1      <= rotate(board_sync1[gw-1:0] | key_joy1, rot, flip);
            m_joy2      <= rotate(board_sync2[gw-1:0] | key_joy2, rot, flip);
            m_joy3      <= rotate(board_sync3[gw-1:0] | key_joy3, rot, flip);
            m_joy4      <= rotate(board_sync4[gw-1:0], rot, flip); // no keyboard for p4
            m_coin      <= coin_all;
            m_start     <= start_all;
            m_joy_pause <= board_sync1[inp_map_pkg::pause_bit]
                         | board_sync2[inp_map_pkg::pause_bit];
        end
    end

endmodule

// File: design/inp_ctrl_stage.sv
`timescale 1ns/1ps

module inp_ctrl_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [inp_map_pkg::game_joy_w-1:0] m_joy1,
    input  logic [inp_map_pkg::game_joy_w-1:0] m_joy2,
    input  logic [inp_map_pkg::game_joy_w-1:0] m_joy3,
    input  logic [inp_map_pkg::game_joy_w-1:0] m_joy4,
    input  logic [inp_map_pkg::n_players-1:0]  m_coin,
    input  logic [inp_map_pkg::n_players-1:0]  m_start,
    input  logic                               m_joy_pause,
    input  logic                               key_pause,
    input  logic                               osd_pause,
    input  logic                               key_reset,
    input  logic                               key_service,
    input  logic                               key_test,
    input  logic                               downloading,
    input  logic                               lock,
    output logic [inp_map_pkg::game_joy_w-1:0] game_joy1,
    output logic [inp_map_pkg::game_joy_w-1:0] game_joy2,
    output logic [inp_map_pkg::game_joy_w-1:0] game_joy3,
    output logic [inp_map_pkg::game_joy_w-1:0] game_joy4,
    output logic [inp_map_pkg::n_players-1:0]  game_coin,
    output logic [inp_map_pkg::n_players-1:0]  game_start,
    output logic                               game_service,
    output logic                               game_test,
    output logic                               game_pause,
    output logic                               soft_rst
);

    localparam logic [inp_map_pkg::game_joy_w-1:0] joy_off =
        {inp_map_pkg::game_joy_w{inp_map_pkg::active_low}};
    localparam logic [inp_map_pkg::n_players-1:0] btn_off =
        {inp_map_pkg::n_players{inp_map_pkg::active_low}};

    logic key_pause_q, osd_pause_q, key_reset_q; // keyboard lines, one flop in
    logic last_pause, last_osd, last_reset, last_joypause;
    logic pause_rise;

    assign pause_rise = (key_pause_q & ~last_pause) | (m_joy_pause & ~last_joypause);

    always_ff @(posedge clk) begin
        if (rst) begin
            key_pause_q   <= 1'b0;
            osd_pause_q   <= 1'b0;
            key_reset_q   <= 1'b0;
            last_pause    <= 1'b0;
            last_osd      <= 1'b0;
            last_reset    <= 1'b0;
            last_joypause <= 1'b0;
            game_joy1     <= joy_off;
            game_joy2     <= joy_off;
            game_joy3     <= joy_off;
            game_joy4     <= joy_off;
            game_coin     <= btn_off;
            game_start    <= btn_off;
            game_service  <= inp_map_pkg::active_low;
            game_test     <= 1'b0;
            game_pause    <= 1'b0;
            soft_rst      <= 1'b0;
        end else begin
            key_pause_q   <= key_pause;
            osd_pause_q   <= osd_pause;
            key_reset_q   <= key_reset;
            last_pause    <= key_pause_q;
            last_osd      <= osd_pause_q;
            last_reset    <= key_reset_q;
            last_joypause <= m_joy_pause;

            game_joy1    <= m_joy1 ^ joy_off;
            game_joy2    <= m_joy2 ^ joy_off;
            game_joy3    <= m_joy3 ^ joy_off;
            game_joy4    <= m_joy4 ^ joy_off;
            game_coin    <= m_coin ^ btn_off;
            game_start   <= m_start ^ btn_off;
            game_service <= key_service ^ inp_map_pkg::active_low;
            game_test    <= key_test; // kept active high

            soft_rst <= key_reset_q & ~last_reset;

            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_pause_q ^ last_osd) begin
                game_pause <= osd_pause_q; // osd wins over a toggle
            end else if (pause_rise) begin
                game_pause <= ~game_pause;
            end

            if (lock) begin
                game_joy1    <= joy_off;
                game_joy2    <= joy_off;
                game_joy3    <= joy_off;
                game_joy4    <= joy_off;
                game_coin    <= btn_off;
                game_start   <= btn_off;
                game_service <= inp_map_pkg::active_low;
                game_pause   <= 1'b0;
            end
        end
    end

endmodule

// File: design/inp_top.sv
`timescale 1ns/1ps

module inp_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic [15:0] board_joy1,
    input  logic [15:0] board_joy2,
    input  logic [15:0] board_joy3,
    input  logic [15:0] board_joy4,
    input  logic        board_coin,
    input  logic        board_start,
    input  logic [9:0]  key_joy1,
    input  logic [9:0]  key_joy2,
    input  logic [9:0]  key_joy3,
    input  logic [3:0]  key_coin,
    input  logic [3:0]  key_start,
    input  logic        key_service,
    input  logic        key_test,
    input  logic        key_pause,
    input  logic        osd_pause,
    input  logic        key_reset,
    input  logic        downloading,
    output logic [9:0]  game_joy1,
    output logic [9:0]  game_joy2,
    output logic [9:0]  game_joy3,
    output logic [9:0]  game_joy4,
    output logic [3:0]  game_coin,
    output logic [3:0]  game_start,
    output logic        game_service,
    output logic        game_test,
    output logic        game_pause,
    output logic        soft_rst
);

    logic        rot, flip, en4way, lock;
    logic [15:0] board_sync1, board_sync2, board_sync3, board_sync4;
    logic        coin_sync, start_sync;
    logic [9:0]  m_joy1, m_joy2, m_joy3, m_joy4;
    logic [3:0]  m_coin, m_start;
    logic        m_joy_pause;

    assign pready = 1'b1; // no wait states

    inp_cfg_apb u_cfg (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
        .game_pause(game_pause), .rot(rot), .flip(flip), .en4way(en4way), .lock(lock)
    );

    inp_sync_stage u_sync (
        .clk(clk), .rst(rst),
        .board_joy1(board_joy1), .board_joy2(board_joy2),
        .board_joy3(board_joy3), .board_joy4(board_joy4),
        .board_coin(board_coin), .board_start(board_start), .en4way(en4way),
        .board_sync1(board_sync1), .board_sync2(board_sync2),
        .board_sync3(board_sync3), .board_sync4(board_sync4),
        .coin_sync(coin_sync), .start_sync(start_sync)
    );

    inp_merge_stage u_merge (
        .clk(clk), .rst(rst),
        .board_sync1(board_sync1), .board_sync2(board_sync2),
        .board_sync3(board_sync3), .board_sync4(board_sync4),
        .coin_sync(coin_sync), .start_sync(start_sync),
        .key_joy1(key_joy1), .key_joy2(key_joy2), .key_joy3(key_joy3),
        .key_coin(key_coin), .key_start(key_start), .rot(rot), .flip(flip),
        .m_joy1(m_joy1), .m_joy2(m_joy2), .m_joy3(m_joy3), .m_joy4(m_joy4),
        .m_coin(m_coin), .m_start(m_start), .m_joy_pause(m_joy_pause)
    );

    inp_ctrl_stage u_ctrl (
        .clk(clk), .rst(rst),
        .m_joy1(m_joy1), .m_joy2(m_joy2), .m_joy3(m_joy3), .m_joy4(m_joy4),
        .m_coin(m_coin), .m_start(m_start), .m_joy_pause(m_joy_pause),
        .key_pause(key_pause), .osd_pause(osd_pause), .key_reset(key_reset),
        .key_service(key_service), .key_test(key_test),
        .downloading(downloading), .lock(lock),
        .game_joy1(game_joy1), .game_joy2(game_joy2),
        .game_joy3(game_joy3), .game_joy4(game_joy4),
        .game_coin(game_coin), .game_start(game_start),
        .game_service(game_service), .game_test(game_test),
        .game_pause(game_pause), .soft_rst(soft_rst)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam time half_period = 50ns; // 100 ns clock

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

// File: tests/inp_checker.sv
`timescale 1ns/1ps

module inp_checker (
    input logic        clk,
    input logic        rst,
    input logic [15:0] board_joy1, board_joy2, board_joy3, board_joy4,
    input logic        board_coin, board_start,
    input logic [9:0]  key_joy1, key_joy2, key_joy3,
    input logic [3:0]  key_coin, key_start,
    input logic        key_service, key_test, key_pause, osd_pause, key_reset,
    input logic        downloading,
    input logic        rot, flip, en4way, lock,
    input logic [9:0]  game_joy1, game_joy2, game_joy3, game_joy4,
    input logic [3:0]  game_coin, game_start,
    input logic        game_service, game_test, game_pause, soft_rst
);

    bit         failed;
    bit         started;
    logic [2:0] run_cnt;
    logic       ready;
    logic [9:0] raw1, raw2, raw3, raw4;
    logic [3:0] coin_raw, start_raw;
    logic       pause_raw;

    // game side view of a merged word, nibble order up down left right
    function automatic logic [9:0] game_view(input logic [9:0] raw, input logic r,
                                             input logic f);
        logic [9:0] turned;
        turned = raw;
        if (r && f)
            turned[3:0] = {raw[0], raw[1], raw[3], raw[2]};
        else if (r)
            turned[3:0] = {raw[1], raw[0], raw[2], raw[3]};
        return ~turned;
    endfunction

    always @(posedge clk) begin
        started <= 1'b1;
        if (rst)
            run_cnt <= 3'd0;
        else if (run_cnt != 3'd7)
            run_cnt <= run_cnt + 3'd1; // saturates once the pipeline is full
    end

    assign ready = run_cnt >= 3'd5;
    assign raw1  = board_joy1[9:0];
    assign raw2  = board_joy2[9:0];
    assign raw3  = board_joy3[9:0];
    assign raw4  = board_joy4[9:0];
    assign pause_raw = board_joy1[inp_map_pkg::pause_bit] | board_joy2[inp_map_pkg::pause_bit];
    assign coin_raw  = {board_joy4[inp_map_pkg::coin_bit], board_joy3[inp_map_pkg::coin_bit],
                        board_joy2[inp_map_pkg::coin_bit],
                        board_joy1[inp_map_pkg::coin_bit] | board_coin};
    assign start_raw = {board_joy4[inp_map_pkg::start_bit], board_joy3[inp_map_pkg::start_bit],
                        board_joy2[inp_map_pkg::start_bit],
                        board_joy1[inp_map_pkg::start_bit] | board_start};

    a_reset_state: assert property (@(posedge clk) started && $past(rst) |->
        (&game_joy1) && (&game_joy2) && (&game_joy3) && (&game_joy4) && (&game_coin)
        && (&game_start) && game_service && !game_pause && !soft_rst)
    else begin
        failed = 1'b1;
        $error("reset_state: outputs not at their inactive values after reset");
    end

    // board words 4 edges back, keyboard 2 edges back
    a_joy1: assert property (@(posedge clk) disable iff (rst)
        ready && !$past(lock) && !$past(en4way, 2) |-> game_joy1 ==
        game_view($past(raw1, 4) | $past(key_joy1, 2), $past(rot, 2), $past(flip, 2)))
    else begin
        failed = 1'b1;
        $error("mismatch joy1: expected %h actual %h", game_view($past(raw1, 4)
               | $past(key_joy1, 2), $past(rot, 2), $past(flip, 2)), $sampled(game_joy1));
    end

    a_joy2: assert property (@(posedge clk) disable iff (rst)
        ready && !$past(lock) && !$past(en4way, 2) |-> game_joy2 ==
        game_view($past(raw2, 4) | $past(key_joy2, 2), $past(rot, 2), $past(flip, 2)))
    else begin
        failed = 1'b1;
        $error("mismatch joy2: expected %h actual %h", game_view($past(raw2, 4)
               | $past(key_joy2, 2), $past(rot, 2), $past(flip, 2)), $sampled(game_joy2));
    end

    a_joy3: assert property (@(posedge clk) disable iff (rst)
        ready && !$past(lock) && !$past(en4way, 2) |-> game_joy3 ==
        game_view($past(raw3, 4) | $past(key_joy3, 2), $past(rot, 2), $past(flip, 2)))
    else begin
        failed = 1'b1;
        $error("mismatch joy3: expected %h actual %h", game_view($past(raw3, 4)
               | $past(key_joy3, 2), $past(rot, 2), $past(flip, 2)), $sampled(game_joy3));
    end

    a_joy4: assert property (@(posedge clk) disable iff (rst)
        ready && !$past(lock) && !$past(en4way, 2) |->
        game_joy4 == game_view($past(raw4, 4), $past(rot, 2), $past(flip, 2)))
    else begin
        failed = 1'b1;
        $error("mismatch joy4: expected %h actual %h",
               game_view($past(raw4, 4), $past(rot, 2), $past(flip, 2)), $sampled(game_joy4));
    end

    a_one_dir: assert property (@(posedge clk) disable iff (rst)
        ready && !$past(lock) && $past(en4way, 2) |-> $onehot0(~game_joy4[3:0]))
    else begin
        failed = 1'b1;
        $error("one_dir: more than one direction active with the 4-way filter on");
    end

    a_coin_start: assert property (@(posedge clk) disable iff (rst)
        ready && !$past(lock) |-> {game_coin, game_start} ==
        ~({$past(coin_raw, 4), $past(start_raw, 4)} | {$past(key_coin, 2), $past(key_start, 2)}))
    else begin
        failed = 1'b1;
        $error("mismatch coin_start: expected %h actual %h", ~({$past(coin_raw, 4),
               $past(start_raw, 4)} | {$past(key_coin, 2), $past(key_start, 2)}),
               $sampled({game_coin, game_start}));
    end

    a_service_test: assert property (@(posedge clk) disable iff (rst)
        ready && !$past(lock) |-> game_service == !$past(key_service)
        && game_test == $past(key_test))
    else begin
        failed = 1'b1;
        $error("mismatch service_test: expected %b%b actual %b%b", !$past(key_service),
               $past(key_test), $sampled(game_service), $sampled(game_test));
    end

    a_lock: assert property (@(posedge clk) disable iff (rst) ready && $past(lock) |->
        (&game_joy1) && (&game_joy2) && (&game_joy3) && (&game_joy4) && (&game_coin)
        && (&game_start) && game_service && !game_pause)
    else begin
        failed = 1'b1;
        $error("lock: an output was active while the inputs were locked");
    end

    a_pause_clear: assert property (@(posedge clk) disable iff (rst)
        ready && ($past(downloading) || $past(lock)) |-> !game_pause)
    else begin
        failed = 1'b1;
        $error("pause_clear: pause set during download or lock");
    end

    a_pause_osd: assert property (@(posedge clk) disable iff (rst)
        ready && !$past(downloading) && !$past(lock)
        && $past(osd_pause, 2) != $past(osd_pause, 3) |-> game_pause == $past(osd_pause, 2))
    else begin
        failed = 1'b1;
        $error("mismatch pause_osd: expected %b actual %b", $past(osd_pause, 2),
               $sampled(game_pause));
    end

    // toggle on a key or synchronized board pause rise, hold otherwise
    a_pause_toggle: assert property (@(posedge clk) disable iff (rst)
        ready && !$past(downloading) && !$past(lock)
        && $past(osd_pause, 2) == $past(osd_pause, 3) |-> game_pause == ($past(game_pause)
        ^ (($past(key_pause, 2) && !$past(key_pause, 3))
        || ($past(pause_raw, 4) && !$past(pause_raw, 5)))))
    else begin
        failed = 1'b1;
        $error("mismatch pause_toggle: expected %b actual %b", $past(game_pause)
               ^ (($past(key_pause, 2) && !$past(key_pause, 3))
               || ($past(pause_raw, 4) && !$past(pause_raw, 5))), $sampled(game_pause));
    end

    a_soft_rst: assert property (@(posedge clk) disable iff (rst)
        ready |-> soft_rst == ($past(key_reset, 2) && !$past(key_reset, 3)))
    else begin
        failed = 1'b1;
        $error("mismatch soft_rst: expected %b actual %b",
               $past(key_reset, 2) && !$past(key_reset, 3), $sampled(soft_rst));
    end

endmodule

bind inp_top inp_checker inp_checker_inst (.*);

// File: tests/inp_tb.sv
`timescale 1ns/1ps

module inp_tb;

    localparam int  stim_cycles  = 400; // rough length of all phases
    localparam int  limit_cycles = 5 * stim_cycles;
    localparam time clk_period   = 100ns;

    logic        clk;
    logic        rst;
    logic        psel, penable, pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready, pslverr;
    logic [15:0] board_joy1, board_joy2, board_joy3, board_joy4;
    logic        board_coin, board_start;
    logic [9:0]  key_joy1, key_joy2, key_joy3;
    logic [3:0]  key_coin, key_start;
    logic        key_service, key_test, key_pause, osd_pause, key_reset, downloading;
    logic [9:0]  game_joy1, game_joy2, game_joy3, game_joy4;
    logic [3:0]  game_coin, game_start;
    logic        game_service, game_test, game_pause, soft_rst;
    integer      seed;

    tb_clock clock_gen (.clk(clk));

    inp_top inp_top_inst (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        fail_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    // wait n rising edges, then step past them
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, input logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        step(1);
        penable = 1'b1; // access phase
        #5;
        assert (pready) else report_mismatch("apb_write_ready", 32'd1, {31'd0, pready});
        assert (pslverr == err) else report_mismatch("apb_write_err", {31'd0, err},
                                                     {31'd0, pslverr});
        step(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input string name, input logic [3:0] addr, input logic [31:0] exp,
                            input logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        step(1);
        penable = 1'b1;
        #5;
        assert (pready) else report_mismatch({name, "_ready"}, 32'd1, {31'd0, pready});
        assert (prdata == exp) else report_mismatch(name, exp, prdata);
        assert (pslverr == err) else report_mismatch({name, "_err"}, {31'd0, err},
                                                     {31'd0, pslverr});
        step(1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic clear_inputs();
        board_joy1  = '0;
        board_joy2  = '0;
        board_joy3  = '0;
        board_joy4  = '0;
        board_coin  = 1'b0;
        board_start = 1'b0;
        key_joy1    = '0;
        key_joy2    = '0;
        key_joy3    = '0;
        key_coin    = '0;
        key_start   = '0;
        key_service = 1'b0;
        key_test    = 1'b0;
        key_pause   = 1'b0;
        osd_pause   = 1'b0;
        key_reset   = 1'b0;
        downloading = 1'b0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = $random(seed);
        board_joy1 = r[15:0];
        board_joy2 = r[31:16];
        r = $random(seed);
        board_joy3 = r[15:0];
        board_joy4 = r[31:16];
        r = $random(seed);
        key_joy1    = r[9:0];
        key_joy2    = r[19:10];
        key_joy3    = r[29:20];
        board_coin  = r[30];
        board_start = r[31];
        r = $random(seed);
        key_coin    = r[3:0];
        key_start   = r[7:4];
        key_service = r[8];
        key_test    = r[9];
        key_pause   = r[10];
        key_reset   = r[11];
        osd_pause   = &r[14:12]; // occasional osd change
    endtask

    task automatic run_random(input int n);
        repeat (n) begin
            drive_random();
            step(1);
        end
    endtask

    task automatic check_dir(input string name, input logic [3:0] dir);
        assert (game_joy1[3:0] == ~dir) else report_mismatch(name, {28'd0, ~dir},
                                                             {28'd0, game_joy1[3:0]});
    endtask

    initial begin
        seed    = 32'h97b3;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        clear_inputs();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        step(1);
        assert (prdata == 32'd0) else report_mismatch("idle_prdata", 32'd0, prdata);
        assert (pslverr == 1'b0) else report_mismatch("idle_slverr", 32'd0, {31'd0, pslverr});

        // register map, lock and flip left on
        apb_write(inp_cfg_pkg::addr_ctrl, 32'h0000_000a, 1'b0);
        apb_read("ctrl_readback", inp_cfg_pkg::addr_ctrl, 32'h0000_000a, 1'b0);
        apb_write(inp_cfg_pkg::addr_status, 32'hffff_ffff, 1'b0);
        apb_read("status_write_ignored", inp_cfg_pkg::addr_ctrl, 32'h0000_000a, 1'b0);
        apb_read("status_read", inp_cfg_pkg::addr_status, 32'd0, 1'b0);
        apb_write(4'h8, 32'h0000_0005, 1'b1);
        apb_read("unmapped_read", 4'hc, 32'd0, 1'b1);
        apb_read("ctrl_after_unmapped", inp_cfg_pkg::addr_ctrl, 32'h0000_000a, 1'b0);
        run_random(20); // locked

        apb_write(inp_cfg_pkg::addr_ctrl, 32'h0, 1'b0);
        run_random(100);
        apb_write(inp_cfg_pkg::addr_ctrl, 32'h1, 1'b0); // rotate
        run_random(50);
        apb_write(inp_cfg_pkg::addr_ctrl, 32'h3, 1'b0); // rotate the other way
        run_random(50);
        apb_write(inp_cfg_pkg::addr_ctrl, 32'h4, 1'b0); // 4-way filter
        run_random(40);

        clear_inputs();
        board_joy1 = 16'h0001; // right alone
        step(3);
        board_joy1 = 16'h0009; // up and right
        step(4);
        check_dir("diag_keeps_right", 4'b0001);
        board_joy1 = 16'h0002;
        step(3);
        board_joy1 = 16'h0009;
        step(4);
        check_dir("diag_vertical_first", 4'b1000);
        board_joy1 = 16'h0006; // down and left, up remembered
        step(4);
        check_dir("diag_down_over_left", 4'b0100);

        apb_write(inp_cfg_pkg::addr_ctrl, 32'h0, 1'b0);
        clear_inputs();
        step(6);
        osd_pause = 1'b1;
        step(3);
        apb_read("pause_from_osd", inp_cfg_pkg::addr_status, 32'h1, 1'b0);
        key_pause = 1'b1;
        step(1);
        key_pause = 1'b0;
        step(3);
        apb_read("pause_toggle_off", inp_cfg_pkg::addr_status, 32'h0, 1'b0);
        key_pause = 1'b1;
        step(2);
        key_pause = 1'b0;
        step(3);
        apb_read("pause_toggle_on", inp_cfg_pkg::addr_status, 32'h1, 1'b0);
        downloading = 1'b1;
        step(2);
        apb_read("pause_download", inp_cfg_pkg::addr_status, 32'h0, 1'b0);
        downloading = 1'b0;
        osd_pause   = 1'b0;
        step(3);
        key_reset = 1'b1;
        step(1);
        key_reset = 1'b0;
        step(3);
        key_reset = 1'b1; // held, still one pulse
        step(4);
        key_reset = 1'b0;
        step(8);

        if (inp_top_inst.inp_checker_inst.failed) begin
            fail_run("a concurrent assertion failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (inp_top_inst.inp_checker_inst.failed)
            fail_run("a concurrent assertion in inp_checker failed");
    end

    initial begin
        #(limit_cycles * clk_period);
        fail_run("timeout: stimulus did not complete in time");
    end

endmodule

// File: flist.f
design/inp_map_pkg.sv
design/inp_cfg_pkg.sv
design/inp_cfg_apb.sv
design/joy_4way_filter.sv
design/inp_sync_stage.sv
design/inp_merge_stage.sv
design/inp_ctrl_stage.sv
design/inp_top.sv
tests/tb_clock.sv
tests/inp_checker.sv
tests/inp_tb.sv
